//--- Bender.yml
package:
  name: uart_rx

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_data_pkg.sv
      - verilog/uart_ctrl_pkg.sv
      - verilog/rx_sampler.sv
      - verilog/frame_sequencer.sv
      - verilog/data_deserializer.sv
      - verilog/rx_holding.sv
      - verilog/uart_rx.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/uart_rx_checker.sv
      - bench/uart_rx_tb.sv

//--- bench/uart_rx_checker.sv
// uart receiver checker: assertions on the output handshake and the reset state
`timescale 1ns/1ns
`default_nettype none

module uart_rx_checker (
  input wire                          clk,
  input wire                          aresetn,
  input wire                          ready,
  input wire                          valid,
  input wire uart_data_pkg::rx_byte_t data,
  input wire                          overflow
);

  int fail_count = 0;  // assertion failures so far

  // ----------------------------------------------------------------------
  // output handshake
  // ----------------------------------------------------------------------

  // held entry stays put until the consumer takes it
  property hold_while_stalled;
    @(posedge clk) disable iff (!aresetn)
      (valid && !ready) |=> (valid && $stable(data));
  endproperty

  property idle_in_reset;
    @(posedge clk) !aresetn |-> !valid;
  endproperty

  // a frame can only be lost while an entry is held
  property overflow_needs_valid;
    @(posedge clk) disable iff (!aresetn)
      $rose(overflow) |-> valid;
  endproperty

  hold_a : assert property (hold_while_stalled)
    else
    begin
      $error("held entry changed while ready was low");
      fail_count++;
    end
  reset_a : assert property (idle_in_reset)
    else
    begin
      $error("valid high during reset");
      fail_count++;
    end
  overflow_a : assert property (overflow_needs_valid)
    else
    begin
      $error("overflow set with no entry held");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- bench/uart_rx_tb.sv
// uart receiver testbench: serial frame driver, reference model and output handshake checks
`timescale 1ns/1ns
`default_nettype none

`include "uart_rx_settings.svh"

module uart_rx_tb;

  localparam int CLKS_PER_BIT = `UART_CLKS_PER_TICK * `UART_OVERSAMPLE;
  localparam int MAX_CYCLES   = 40 * 12 * CLKS_PER_BIT * 2;  // 40 frames of 12 bits, doubled

  logic       clk;
  logic       aresetn;
  logic       rx;
  logic       bit8;
  logic       parity_en;
  logic       odd_n_even;
  logic       ready;
  logic       valid;
  logic [7:0] data;
  logic       parity_err;
  logic       framing_err;
  logic       overflow;

  logic [9:0] exp_q[$];       // {data, parity_err, framing_err} per delivered frame
  logic [9:0] exp_entry;
  logic [7:0] value;
  logic [7:0] held;           // first byte of the back-pressure test
  integer     seed = 96;
  int         error_count = 0;
  int         errors_before = 0;
  int         xfer_count = 0;
  int         xfers_before = 0;
  int         tests_passed = 0;
  int         tests_failed = 0;
  int         cycles = 0;

  uart_rx dut_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .rx          (rx),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .odd_n_even  (odd_n_even),
    .ready       (ready),
    .valid       (valid),
    .data        (data),
    .parity_err  (parity_err),
    .framing_err (framing_err),
    .overflow    (overflow)
  );

  bind uart_rx uart_rx_checker checker_i (
    .clk      (clk),
    .aresetn  (aresetn),
    .ready    (ready),
    .valid    (valid),
    .data     (data),
    .overflow (overflow)
  );

  // ----------------------------------------------------------------------
  // reference model and helpers
  // ----------------------------------------------------------------------

  // what the receiver must hand over for one frame
  function automatic logic [9:0] expected_result(input logic [7:0] byte_in, input logic b8,
                                                 input logic pe, input logic odd,
                                                 input logic bad_par, input logic bad_stop);
    logic [7:0] exp_data;
    logic       ones;      // odd count of ones among the data bits
    logic       sent_par;
    begin
      exp_data = b8 ? byte_in : {1'b0, byte_in[6:0]};
      ones     = ^exp_data;
      sent_par = ones ^ odd ^ bad_par;           // a correct bit makes the total match odd
      return {exp_data, pe & ((ones ^ sent_par) != odd), bad_stop};
    end
  endfunction

  // compare mismatches plus failed handshake assertions
  function automatic int total_errors();
    begin
      return error_count + dut_i.checker_i.fail_count;
    end
  endfunction

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
    begin
      if (got !== want)
      begin
        $display("FAIL %s: got 0x%02h, expected 0x%02h", name, got, want);
        error_count++;
      end
    end
  endtask

  task automatic next_byte(output logic [7:0] v);
    logic [31:0] rnd;
    begin
      rnd = $random(seed);
      v   = rnd[7:0];
    end
  endtask

  // hold rx at a level for a number of clocks, changed just after the edge
  task automatic line_level(input logic level, input int clocks);
    begin
      @(posedge clk);
      #5 rx = level;
      repeat (clocks - 1) @(posedge clk);
    end
  endtask

  task automatic send_frame(input logic [7:0] byte_in, input logic bad_par,
                            input logic bad_stop, input logic deliver);
    int   nbits;
    logic par;
    begin
      nbits = bit8 ? 8 : 7;
      par   = odd_n_even ^ bad_par;             // even starts from zero, odd from one
      if (deliver)
        exp_q.push_back(expected_result(byte_in, bit8, parity_en, odd_n_even,
                                        bad_par, bad_stop));
      line_level(1'b0, CLKS_PER_BIT);           // start bit
      for (int i = 0; i < nbits; i++)
      begin
        line_level(byte_in[i], CLKS_PER_BIT);   // LSB first
        par = par ^ byte_in[i];
      end
      if (parity_en)
        line_level(par, CLKS_PER_BIT);
      line_level(~bad_stop, CLKS_PER_BIT);
      line_level(1'b1, 2 * CLKS_PER_BIT);      // idle gap, filter and FSM settle
    end
  endtask

  task automatic set_config(input logic b8, input logic pe, input logic odd);
    begin
      @(posedge clk);
      #5;
      bit8       = b8;
      parity_en  = pe;
      odd_n_even = odd;
    end
  endtask

  task automatic set_ready(input logic r);
    begin
      @(posedge clk);
      #5 ready = r;
    end
  endtask

  task automatic start_test();
    begin
      errors_before = total_errors();
      xfers_before  = xfer_count;
    end
  endtask

  task automatic finish_test(input string name);
    begin
      while (exp_q.size() != 0)
        @(posedge clk);                         // watchdog ends a stuck run
      if (total_errors() == errors_before)
      begin
        tests_passed++;
        $display("test %s: ok", name);
      end
      else
      begin
        tests_failed++;
        $display("test %s: %0d errors", name, total_errors() - errors_before);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // clock, watchdog and compare
  // ----------------------------------------------------------------------
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("run timed out after %0d cycles, %0d frames outstanding", cycles, exp_q.size());
      $display("Simulation failed");
      $finish;
    end
  end

  // negedge sample, valid and ready are settled mid cycle
  always @(negedge clk)
  begin
    if (aresetn && valid && ready)
    begin
      xfer_count++;
      if (exp_q.size() == 0)
      begin
        $display("transfer of data 0x%02h happened with no frame sent", data);
        error_count++;
      end
      else
      begin
        exp_entry = exp_q.pop_front();
        check_value("data", data, exp_entry[9:2]);
        check_value("parity_err", 8'(parity_err), 8'(exp_entry[1]));
        check_value("framing_err", 8'(framing_err), 8'(exp_entry[0]));
      end
    end
  end

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------
  initial
  begin
    aresetn    = 1'b0;
    rx         = 1'b1;
    bit8       = 1'b1;
    parity_en  = 1'b0;
    odd_n_even = 1'b0;
    ready      = 1'b1;
    repeat (16) @(posedge clk);
    #5 aresetn = 1'b1;
    line_level(1'b1, 2 * CLKS_PER_BIT);

    start_test();
    repeat (8)
    begin
      next_byte(value);
      send_frame(value, 1'b0, 1'b0, 1'b1);
    end
    finish_test("8N1 random bytes");

    // modes 7N, 7O, 7E, 8O, 8E, middle frame of each carries a bad parity bit
    start_test();
    for (int mode = 0; mode < 5; mode++)
    begin
      set_config(mode >= 3, mode != 0, mode[0]);
      for (int n = 0; n < 3; n++)
      begin
        next_byte(value);
        send_frame(value, n == 1, 1'b0, 1'b1);
      end
    end
    finish_test("7/8 bit and parity");
    set_config(1'b1, 1'b0, 1'b0);

    start_test();
    next_byte(value);
    send_frame(value, 1'b0, 1'b1, 1'b1);        // low stop bit
    next_byte(value);
    send_frame(value, 1'b0, 1'b0, 1'b1);
    finish_test("framing error and recovery");

    start_test();
    line_level(1'b0, `UART_CLKS_PER_TICK);     // one tick, a single low sample
    line_level(1'b1, 10 * CLKS_PER_BIT);       // long enough for a false frame to finish
    if (xfer_count != xfers_before)
    begin
      $display("a short low pulse on rx produced a transfer");
      error_count++;
    end
    next_byte(value);
    send_frame(value, 1'b0, 1'b0, 1'b1);
    finish_test("glitch rejection");

    start_test();
    set_ready(1'b0);
    next_byte(held);
    send_frame(held, 1'b0, 1'b0, 1'b1);
    next_byte(value);
    send_frame(value, 1'b0, 1'b0, 1'b0);        // dropped, sets overflow
    @(negedge clk);
    check_value("valid", 8'(valid), 8'h01);
    check_value("data", data, held);
    check_value("overflow", 8'(overflow), 8'h01);
    set_ready(1'b1);
    while (exp_q.size() != 0)
      @(posedge clk);
    @(negedge clk);
    check_value("overflow", 8'(overflow), 8'h00);
    next_byte(value);
    send_frame(value, 1'b0, 1'b0, 1'b1);
    finish_test("back-pressure and overflow");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors() == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/uart_data_pkg.sv
verilog/uart_ctrl_pkg.sv
verilog/rx_sampler.sv
verilog/frame_sequencer.sv
verilog/data_deserializer.sv
verilog/rx_holding.sv
verilog/uart_rx.sv
bench/uart_rx_checker.sv
bench/uart_rx_tb.sv

//--- verilog/data_deserializer.sv
// uart data deserializer: shift register, running parity and parity verdict
`timescale 1ns/1ns
`default_nettype none

module data_deserializer (
  input  wire                       clk,
  input  wire                       aresetn,
  input  wire                       rx_clean,     // filtered line
  input  wire                       frame_start,  // clears the frame
  input  wire                       bit_strobe,   // sample rx_clean now
  input  wire                       bit8,
  input  wire                       parity_en,
  input  wire                       odd_n_even,   // odd parity when high
  output uart_data_pkg::rx_byte_t   rx_byte,      // data bits aligned to bit 0
  output logic                      parity_bad
);

  import uart_data_pkg::*;

  rx_shift_t  shift_q;     // bits enter at the top, LSB first
  rx_shift_t  aligned;     // shift_q moved down to bit 0
  bit_count_t strobe_cnt;  // bits taken in this frame
  bit_count_t data_bits;   // 7 or 8
  bit_count_t pad;         // unfilled positions at the bottom of shift_q
  logic       data_xor;    // xor of the data bits only
  logic       par_bit;     // received parity bit

  assign data_bits = bit_count_t'(7) + bit_count_t'(bit8);
  assign pad       = bit_count_t'(2) - bit_count_t'(bit8) - bit_count_t'(parity_en);

  // ----------------------------------------------------------------------
  // shift register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      shift_q <= '0;
    else if (frame_start)
      shift_q <= '0;
    else if (bit_strobe)
      shift_q <= {rx_clean, shift_q[8:1]};
  end

  // ----------------------------------------------------------------------
  // bit count and parity
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      strobe_cnt <= '0;
      data_xor   <= 1'b0;
      par_bit    <= 1'b0;
    end
    else if (frame_start)
    begin
      strobe_cnt <= '0;
      data_xor   <= 1'b0;
      par_bit    <= 1'b0;
    end
    else if (bit_strobe)
    begin
      strobe_cnt <= strobe_cnt + bit_count_t'(1);
      if (strobe_cnt < data_bits)
        data_xor <= data_xor ^ rx_clean;
      else
        par_bit <= rx_clean;   // only reached with parity_en
    end
  end

  // ----------------------------------------------------------------------
  // outputs, final one clock after the last strobe
  // ----------------------------------------------------------------------
  assign aligned = shift_q >> pad;
  assign rx_byte = {bit8 & aligned[7], aligned[6:0]};  // parity bit lands on bit 7 in 7E/7O

  // even wants an even count of ones, odd wants an odd count
  assign parity_bad = parity_en & (data_xor ^ par_bit ^ odd_n_even);

endmodule

`default_nettype wire

//--- verilog/frame_sequencer.sv
// uart frame sequencer: bit timing, frame FSM, start qualification and stop-bit check
`timescale 1ns/1ns
`default_nettype none

`include "uart_rx_settings.svh"

module frame_sequencer (
  input  wire  clk,
  input  wire  aresetn,
  input  wire  tick,         // oversampling tick
  input  wire  rx_clean,     // filtered line
  input  wire  bit8,         // 8 data bits when high, else 7
  input  wire  parity_en,    // parity bit follows the data
  output logic frame_start,  // start bit confirmed
  output logic bit_strobe,   // middle of a data or parity bit
  output logic frame_done,   // middle of the stop bit
  output logic stop_bad      // stop sample was low, valid with frame_done
);

  import uart_data_pkg::*;
  import uart_ctrl_pkg::*;

  frame_state_t state;
  tick_count_t  tick_cnt;   // ticks since the last sample point
  bit_count_t   bit_cnt;    // bits sampled so far in this frame
  bit_count_t   last_bit;   // index of the final data or parity bit
  logic         mid_hit;    // start bit middle reached
  logic         bit_end;    // one full bit period elapsed

  // ----------------------------------------------------------------------
  // sample points
  // ----------------------------------------------------------------------
  assign mid_hit = (tick_cnt == tick_count_t'(`UART_MID_TICK));
  assign bit_end = (tick_cnt == tick_count_t'(`UART_OVERSAMPLE));

  // strobes decode straight from state so the deserializer samples
  // rx_clean on the same clock as this FSM does
  assign frame_start = tick & (state == st_start) & mid_hit & ~rx_clean;
  assign bit_strobe  = tick & (state == st_data) & bit_end;
  assign frame_done  = tick & (state == st_stop) & bit_end;
  assign stop_bad    = frame_done & ~rx_clean;   // framing error

  // ----------------------------------------------------------------------
  // frame FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state    <= st_idle;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      last_bit <= '0;
    end
    else if (tick)
    begin
      case (state)
        st_idle:
        begin
          if (!rx_clean)
          begin
            state    <= st_start;  // possible start edge
            tick_cnt <= tick_count_t'(1);
          end
        end

        st_start:
        begin
          if (mid_hit)
          begin
            if (rx_clean)
              state <= st_idle;    // glitch, line went back high
            else
            begin
              state    <= st_data;
              tick_cnt <= tick_count_t'(1);
              bit_cnt  <= '0;
              // 7 + bit8 + parity_en bits follow, config is static per frame
              last_bit <= bit_count_t'(6) + bit_count_t'(bit8) + bit_count_t'(parity_en);
            end
          end
          else
            tick_cnt <= tick_cnt + tick_count_t'(1);
        end

        st_data:
        begin
          if (bit_end)
          begin
            tick_cnt <= tick_count_t'(1);
            bit_cnt  <= bit_cnt + bit_count_t'(1);
            if (bit_cnt == last_bit)
              state <= st_stop;    // that was the last data or parity bit
          end
          else
            tick_cnt <= tick_cnt + tick_count_t'(1);
        end

        st_stop:
        begin
          if (bit_end)
            state <= rx_clean ? st_idle : st_wait_high;
          else
            tick_cnt <= tick_cnt + tick_count_t'(1);
        end

        st_wait_high:
        begin
          // a low stop bit would look like a new start edge
          if (rx_clean)
            state <= st_idle;
        end

        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/rx_holding.sv
// uart rx holding stage: one-entry output register with valid/ready and sticky overflow
`timescale 1ns/1ns
`default_nettype none

module rx_holding (
  input  wire                     clk,
  input  wire                     aresetn,
  input  wire                     frame_done,  // new frame complete
  input  wire uart_data_pkg::rx_byte_t rx_byte,
  input  wire                     parity_bad,
  input  wire                     stop_bad,
  input  wire                     ready,       // consumer takes the entry
  output logic                    valid,
  output uart_data_pkg::rx_byte_t data,
  output logic                    parity_err,
  output logic                    framing_err,
  output logic                    overflow     // a frame was dropped
);

  logic xfer;  // transfer on this clock
  logic take;  // load the register from the receiver

  assign xfer = valid & ready;
  assign take = frame_done & (~valid | xfer);  // empty, or emptying this clock

  // ----------------------------------------------------------------------
  // entry register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      valid       <= 1'b0;
      data        <= '0;
      parity_err  <= 1'b0;
      framing_err <= 1'b0;
    end
    else if (take)
    begin
      valid       <= 1'b1;
      data        <= rx_byte;
      parity_err  <= parity_bad;
      framing_err <= stop_bad;
    end
    else if (xfer)
      valid <= 1'b0;
  end

  // overflow is sticky until the consumer takes the held entry
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      overflow <= 1'b0;
    else if (xfer)
      overflow <= 1'b0;
    else if (frame_done & valid)
      overflow <= 1'b1;   // entry still held, new frame lost
  end

endmodule

`default_nettype wire

//--- verilog/rx_sampler.sv
// uart rx sampler: oversampling tick divider, input synchronizer and majority filter
`timescale 1ns/1ns
`default_nettype none

`include "uart_rx_settings.svh"

module rx_sampler (
  input  wire  clk,
  input  wire  aresetn,
  input  wire  rx,        // raw serial line, idle high
  output logic tick,      // one clock every UART_CLKS_PER_TICK clocks
  output logic rx_clean   // filtered line
);

  import uart_data_pkg::*;

  clk_div_t   div_cnt;    // clocks within the current tick
  logic [1:0] sync_q;     // two-flop synchronizer, [1] is the safe copy
  logic [2:0] window;     // last three samples taken on tick

  // ----------------------------------------------------------------------
  // tick divider
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end
    else if (div_cnt == clk_div_t'(`UART_CLKS_PER_TICK - 1))
    begin
      div_cnt <= '0;
      tick    <= 1'b1;  // registered, so the pulse is glitch free
    end
    else
    begin
      div_cnt <= div_cnt + clk_div_t'(1);
      tick    <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // synchronizer and sample window
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      sync_q <= 2'b11;   // line idles high
      window <= 3'b111;
    end
    else
    begin
      sync_q <= {sync_q[0], rx};
      if (tick)
        window <= {sync_q[1], window[2:1]};  // newest sample enters at the top
    end
  end

  // two out of three wins, a single bad sample never reaches the FSM
  assign rx_clean = (window[0] & window[1]) |
                    (window[0] & window[2]) |
                    (window[1] & window[2]);

endmodule

`default_nettype wire

//--- verilog/uart_ctrl_pkg.sv
// uart receiver control types: states of the frame FSM
`default_nettype none

package uart_ctrl_pkg;

  // frame FSM states
  typedef enum logic [2:0] {
    st_idle      = 3'd0,  // line idle, looking for a low sample
    st_start     = 3'd1,  // start bit qualification
    st_data      = 3'd2,  // data and parity bits
    st_stop      = 3'd3,  // waiting for the stop bit middle
    st_wait_high = 3'd4   // stop bit was low, wait for the line to return high
  } frame_state_t;

endpackage

`default_nettype wire

//--- verilog/uart_data_pkg.sv
// uart receiver data types: widths of the byte, shift register and counters
`default_nettype none

package uart_data_pkg;

  // ----------------------------------------------------------------------
  // payload
  // ----------------------------------------------------------------------

  // received byte, bit 7 is zero in 7-bit mode
  typedef logic [7:0] rx_byte_t;

  // up to 8 data bits plus the parity bit, filled from the top
  typedef logic [8:0] rx_shift_t;

  // ----------------------------------------------------------------------
  // counters
  // ----------------------------------------------------------------------

  // bits sampled in one frame, at most 9
  typedef logic [3:0] bit_count_t;

  // oversampling ticks within one bit period, 1 to 8
  typedef logic [3:0] tick_count_t;

  // system clocks within one oversampling tick
  typedef logic [7:0] clk_div_t;

endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
// uart receiver top: sampler, frame sequencer, deserializer and holding stage
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
  input  wire                     clk,
  input  wire                     aresetn,
  input  wire                     rx,          // serial line, idle high
  input  wire                     bit8,        // static config, change only while idle
  input  wire                     parity_en,
  input  wire                     odd_n_even,
  input  wire                     ready,
  output logic                    valid,
  output uart_data_pkg::rx_byte_t data,
  output logic                    parity_err,
  output logic                    framing_err,
  output logic                    overflow
);

  import uart_data_pkg::*;

  logic     tick;
  logic     rx_clean;
  logic     frame_start;
  logic     bit_strobe;
  logic     frame_done;
  logic     stop_bad;
  logic     parity_bad;
  rx_byte_t rx_byte;

  rx_sampler sampler_i (
    .clk      (clk),
    .aresetn  (aresetn),
    .rx       (rx),
    .tick     (tick),
    .rx_clean (rx_clean)
  );

  // sequencer and deserializer see the same filtered stream
  frame_sequencer sequencer_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .tick        (tick),
    .rx_clean    (rx_clean),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .frame_start (frame_start),
    .bit_strobe  (bit_strobe),
    .frame_done  (frame_done),
    .stop_bad    (stop_bad)
  );

  data_deserializer deserializer_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .rx_clean    (rx_clean),
    .frame_start (frame_start),
    .bit_strobe  (bit_strobe),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .odd_n_even  (odd_n_even),
    .rx_byte     (rx_byte),
    .parity_bad  (parity_bad)
  );

  rx_holding holding_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .frame_done  (frame_done),
    .rx_byte     (rx_byte),
    .parity_bad  (parity_bad),
    .stop_bad    (stop_bad),
    .ready       (ready),
    .valid       (valid),
    .data        (data),
    .parity_err  (parity_err),
    .framing_err (framing_err),
    .overflow    (overflow)
  );

endmodule

`default_nettype wire

//--- verilog/uart_rx_settings.svh
// uart receiver settings: tick divider, oversampling ratio and mid-bit sample point
`ifndef UART_RX_SETTINGS_SVH
`define UART_RX_SETTINGS_SVH

// ----------------------------------------------------------------------
// oversampling clock
// ----------------------------------------------------------------------

// system clocks per oversampling tick
// baud rate = f_clk / (UART_CLKS_PER_TICK * UART_OVERSAMPLE)
`define UART_CLKS_PER_TICK 4

// ticks per bit period
`define UART_OVERSAMPLE 8

// ----------------------------------------------------------------------
// sample point
// ----------------------------------------------------------------------

// tick count at which the start bit is confirmed, counted from the
// detected falling edge; half a bit period puts every later sample
// near the middle of its bit
`define UART_MID_TICK 4

`endif
